// File: design/hawk_defines.svh
////////////////////
// hawk front end sizes
// line, chunk and page geometry, dram base, compression threshold
////////////////////
`ifndef HAWK_DEFINES_SVH
`define HAWK_DEFINES_SVH

// bus widths
`define HAWK_ADDR_W       32               // cpu and memory address
`define HAWK_LINE_W       128              // one cache line
`define HAWK_CHUNK_W      32               // compressor granule

// page geometry
`define HAWK_CHUNKS       4                // chunks per line
`define HAWK_PAGE_LINES   8                // lines per page
`define HAWK_LINE_BYTES   16               // line stride in memory
`define HAWK_CHUNK_BYTES  4                // bytes per stored chunk

`define HAWK_DRAM_BASE    32'h8000_0000    // cpu view of dram start
`define HAWK_COMP_THRESH  64               // above this, page stays raw
`define HAWK_SIZE_W       8                // compressed size field

`endif

// File: design/hawk_mem_pkg.sv
////////////////////
// hawk memory side types
// cpu and memory controller strobe port bundles
////////////////////
`include "hawk_defines.svh"

package hawk_mem_pkg;

   // cpu request, one strobe per access
   typedef struct packed {
      logic                    valid;   // request strobe
      logic                    we;      // 1 write, 0 read
      logic [`HAWK_ADDR_W-1:0] addr;    // byte address
      logic [`HAWK_LINE_W-1:0] wdata;   // full line write data
   } cpu_req_t;

   typedef struct packed {
      logic                    valid;   // read return pulse
      logic [`HAWK_LINE_W-1:0] rdata;
   } cpu_resp_t;

   // memory controller side, same layout as cpu
   typedef struct packed {
      logic                    valid;
      logic                    we;
      logic [`HAWK_ADDR_W-1:0] addr;    // rebased address
      logic [`HAWK_LINE_W-1:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic                    valid;   // in order, reads only
      logic [`HAWK_LINE_W-1:0] rdata;
   } mem_resp_t;

endpackage

// File: design/hawk_comp_pkg.sv
////////////////////
// hawk compressor types
// line views, control states, page result
////////////////////
`include "hawk_defines.svh"

package hawk_comp_pkg;

   // one line, flat for the cpu, chunked for the compressor
   typedef union packed {
      logic [`HAWK_LINE_W-1:0]                      flat;
      logic [`HAWK_CHUNKS-1:0][`HAWK_CHUNK_W-1:0]   chunk;  // chunk[0] is low word
   } hawk_line_u;

   // page operation sequence
   typedef enum logic [2:0] {
      IDLE    = 3'd0,   // cpu owns memory
      DRAIN   = 3'd1,   // wait out cpu reads
      ISSUE   = 3'd2,   // one line read per cycle
      COLLECT = 3'd3,   // wait last line
      DONE    = 3'd4    // one cycle done pulse
   } ctrl_state_e;

   typedef struct packed {
      logic [`HAWK_PAGE_LINES-1:0] zero_vec;  // bit n set, line n all zero
      logic [`HAWK_SIZE_W-1:0]     size;      // compressed bytes
      logic                        incomp;    // size over threshold
   } comp_result_t;

endpackage

// File: design/hawk_ctrl_fsm.sv
////////////////////
// hawk page operation FSM
// drains cpu reads, reads one page, hands result back
////////////////////
`timescale 1ns/1ps

module hawk_ctrl_fsm
   import hawk_comp_pkg::*;
(
   input  logic clk_i,
   input  logic arst_n_i,
   input  logic cmd_start_i,      // one cycle pulse
   input  logic hawk_inactive_i,  // engine off, cpu path unaffected
   input  logic cpu_rd_idle_i,    // no cpu read in flight
   input  logic issue_last_i,     // eighth line read going out
   input  logic resp_last_i,      // eighth line data back
   output logic busy_o,           // hold off cpu
   output logic eng_own_o,        // engine drives memory
   output logic issue_en_o,
   output logic clear_o,
   output logic finish_o,
   output logic cmd_done_o
);

   ctrl_state_e state_q, state_d;
   logic        start_ok;

   assign start_ok = cmd_start_i & ~hawk_inactive_i;  // start dropped while inactive

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (start_ok) state_d = DRAIN;
         end
         DRAIN: begin
            // at least one cycle, a read forwarded with start is counted by now
            if (cpu_rd_idle_i) state_d = ISSUE;
         end
         ISSUE: begin
            if (issue_last_i) state_d = COLLECT;  // exactly 8 cycles
         end
         COLLECT: begin
            if (resp_last_i) state_d = DONE;
         end
         DONE: begin
            state_d = IDLE;
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign busy_o     = (state_q != IDLE);                         // through DONE
   assign eng_own_o  = (state_q == ISSUE) | (state_q == COLLECT);
   assign issue_en_o = (state_q == ISSUE);
   assign clear_o    = (state_q == IDLE) & start_ok;              // fresh counters
   assign finish_o   = (state_q == COLLECT) & resp_last_i;        // result lands with DONE
   assign cmd_done_o = (state_q == DONE);

endmodule

// File: design/hawk_line_counter.sv
////////////////////
// hawk line counters
// lines issued and lines returned for one page
////////////////////
`timescale 1ns/1ps
`include "hawk_defines.svh"

module hawk_line_counter (
   input  logic                                 clk_i,
   input  logic                                 arst_n_i,
   input  logic                                 clear_i,       // page start
   input  logic                                 issue_en_i,    // one read per cycle
   input  logic                                 resp_valid_i,  // engine line back
   output logic [$clog2(`HAWK_PAGE_LINES)-1:0]  issue_idx_o,   // line being read
   output logic                                 issue_last_o,
   output logic                                 resp_last_o
);

   logic [$clog2(`HAWK_PAGE_LINES)-1:0] issue_cnt_q;  // wraps after the eighth
   logic [$clog2(`HAWK_PAGE_LINES)-1:0] resp_cnt_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         issue_cnt_q <= '0;
         resp_cnt_q  <= '0;
      end else if (clear_i) begin
         issue_cnt_q <= '0;
         resp_cnt_q  <= '0;
      end else begin
         if (issue_en_i)   issue_cnt_q <= issue_cnt_q + 1'b1;
         if (resp_valid_i) resp_cnt_q  <= resp_cnt_q + 1'b1;
      end
   end

   assign issue_idx_o  = issue_cnt_q;
   // eighth event, flagged in its own cycle
   assign issue_last_o = issue_en_i & (issue_cnt_q == ($clog2(`HAWK_PAGE_LINES))'(`HAWK_PAGE_LINES - 1));
   assign resp_last_o  = resp_valid_i & (resp_cnt_q == ($clog2(`HAWK_PAGE_LINES))'(`HAWK_PAGE_LINES - 1));

endmodule

// File: design/hawk_zero_detect.sv
////////////////////
// hawk zero chunk detector
// marks all zero lines, counts live chunks, sizes the page
////////////////////
`timescale 1ns/1ps
`include "hawk_defines.svh"

module hawk_zero_detect
   import hawk_mem_pkg::*, hawk_comp_pkg::*;
(
   input  logic         clk_i,
   input  logic         arst_n_i,
   input  logic         clear_i,   // page start
   input  mem_resp_t    line_i,    // engine read return
   input  logic         finish_i,  // last line on line_i now
   output comp_result_t result_o
);

   hawk_line_u                          line_v;     // chunk view of the return
   logic [$clog2(`HAWK_CHUNKS+1)-1:0]   line_nz;    // live chunks in this line
   logic                                line_zero;
   logic [`HAWK_PAGE_LINES-1:0]         zvec_q, zvec_d;
   logic [`HAWK_SIZE_W-1:0]             nz_q, nz_d; // live chunks so far
   logic [`HAWK_SIZE_W-1:0]             size_d;
   comp_result_t                        result_q;

   always_comb begin
      line_v.flat = line_i.rdata;
      line_nz     = '0;
      for (int i = 0; i < `HAWK_CHUNKS; i++) begin
         if (line_v.chunk[i] != '0) line_nz = line_nz + 1'b1;
      end
      line_zero = (line_nz == '0);
   end

   // shift in from the top, line 0 ends at bit 0
   assign zvec_d = line_i.valid ? {line_zero, zvec_q[`HAWK_PAGE_LINES-1:1]} : zvec_q;
   assign nz_d   = line_i.valid ? nz_q + `HAWK_SIZE_W'(line_nz) : nz_q;
   assign size_d = nz_d * `HAWK_SIZE_W'(`HAWK_CHUNK_BYTES);  // includes current line

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         zvec_q   <= '0;
         nz_q     <= '0;
         result_q <= '0;
      end else begin
         if (clear_i) begin
            zvec_q <= '0;
            nz_q   <= '0;
         end else begin
            zvec_q <= zvec_d;  // one cycle per response
            nz_q   <= nz_d;
         end
         if (finish_i) begin
            result_q.zero_vec <= zvec_d;
            result_q.size     <= size_d;
            result_q.incomp   <= (size_d > `HAWK_SIZE_W'(`HAWK_COMP_THRESH));
         end
      end
   end

   assign result_o = result_q;  // held until next finish

endmodule

// File: design/hawk_cpu_stall.sv
////////////////////
// hawk cpu stall
// rebases cpu addresses, parks one request while engine busy
////////////////////
`timescale 1ns/1ps
`include "hawk_defines.svh"

module hawk_cpu_stall
   import hawk_mem_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  logic     uart_boot_en_i,  // boot, addresses used as is
   input  logic     busy_i,          // page operation running
   input  cpu_req_t cpu_req_i,
   output cpu_req_t fwd_req_o,       // to memory mux
   output logic     cpu_stall_o
);

   cpu_req_t req_rb;      // rebased request
   cpu_req_t hold_q;      // parked request
   logic     hold_vld_q;
   logic     capture;

   always_comb begin
      req_rb = cpu_req_i;
      if (!uart_boot_en_i) begin
         req_rb.addr = cpu_req_i.addr - `HAWK_DRAM_BASE;  // dram at zero on the mc
      end
   end

   assign capture = cpu_req_i.valid & busy_i;  // one deep, cpu waits on stall

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         hold_vld_q <= 1'b0;
      end else if (capture) begin
         hold_vld_q <= 1'b1;
      end else if (!busy_i) begin
         hold_vld_q <= 1'b0;  // released this cycle
      end
   end

   always_ff @(posedge clk_i) begin
      if (capture) hold_q <= req_rb;
   end

   always_comb begin
      fwd_req_o = req_rb;                            // straight through when idle
      if (hold_vld_q) fwd_req_o = hold_q;            // parked one goes first
      fwd_req_o.valid = fwd_req_o.valid & ~busy_i;   // nothing out while busy
   end

   assign cpu_stall_o = hold_vld_q;  // drops cycle after release

endmodule

// File: design/hawk_mem_mux.sv
////////////////////
// hawk memory port mux
// engine or cpu on the mc port, read returns steered back
////////////////////
`timescale 1ns/1ps
`include "hawk_defines.svh"

module hawk_mem_mux
   import hawk_mem_pkg::*;
(
   input  logic                                clk_i,
   input  logic                                arst_n_i,
   input  logic                                eng_own_i,
   input  cpu_req_t                            fwd_req_i,
   input  logic                                issue_en_i,
   input  logic [$clog2(`HAWK_PAGE_LINES)-1:0] issue_idx_i,
   input  logic [`HAWK_ADDR_W-1:0]             cmd_page_i,  // stable for the whole op
   input  mem_resp_t                           mem_resp_i,
   output mem_req_t                            mem_req_o,
   output cpu_resp_t                           cpu_resp_o,
   output mem_resp_t                           eng_resp_o,
   output logic                                cpu_rd_idle_o
);

   logic [7:0]              rd_cnt_q;   // cpu reads in flight
   logic                    cpu_rd_issue;
   logic                    rd_ret;     // return belongs to cpu
   logic [`HAWK_ADDR_W-1:0] line_addr;

   assign line_addr = cmd_page_i
                    + `HAWK_ADDR_W'(issue_idx_i) * `HAWK_ADDR_W'(`HAWK_LINE_BYTES);

   always_comb begin
      if (eng_own_i) begin
         mem_req_o.valid = issue_en_i;  // line reads only
         mem_req_o.we    = 1'b0;
         mem_req_o.addr  = line_addr;
         mem_req_o.wdata = '0;
      end else begin
         mem_req_o.valid = fwd_req_i.valid;
         mem_req_o.we    = fwd_req_i.we;
         mem_req_o.addr  = fwd_req_i.addr;
         mem_req_o.wdata = fwd_req_i.wdata;
      end
   end

   assign cpu_rd_issue = fwd_req_i.valid & ~fwd_req_i.we & ~eng_own_i;
   assign rd_ret       = mem_resp_i.valid & (rd_cnt_q != '0);  // in order, cpu first

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_cnt_q <= '0;
      end else begin
         case ({cpu_rd_issue, rd_ret})
            2'b10:   rd_cnt_q <= rd_cnt_q + 1'b1;
            2'b01:   rd_cnt_q <= rd_cnt_q - 1'b1;
            default: rd_cnt_q <= rd_cnt_q;  // both or neither
         endcase
      end
   end

   assign cpu_resp_o.valid = rd_ret;
   assign cpu_resp_o.rdata = mem_resp_i.rdata;
   assign eng_resp_o.valid = mem_resp_i.valid & (rd_cnt_q == '0);  // rest is page data
   assign eng_resp_o.rdata = mem_resp_i.rdata;
   assign cpu_rd_idle_o    = (rd_cnt_q == '0);

endmodule

// File: design/hawk_core.sv
////////////////////
// hawk compression front end
// cpu stall and rebase, mc port mux, zero chunk page compressor
////////////////////
`timescale 1ns/1ps
`include "hawk_defines.svh"

module hawk_core
   import hawk_mem_pkg::*, hawk_comp_pkg::*;
(
   input  logic                    clk_i,
   input  logic                    arst_n_i,
   input  logic                    uart_boot_en_i,
   input  logic                    hawk_inactive_i,
   input  cpu_req_t                cpu_req_i,
   input  logic                    cmd_start_i,
   input  logic [`HAWK_ADDR_W-1:0] cmd_page_i,   // page base on the mc
   input  mem_resp_t               mem_resp_i,
   output logic                    cpu_stall_o,
   output cpu_resp_t               cpu_resp_o,
   output mem_req_t                mem_req_o,
   output logic                    cmd_done_o,
   output comp_result_t            result_o
);

   ////////////////////
   // internal wiring
   ////////////////////
   logic                                busy;         // fsm to stall unit
   logic                                eng_own;      // fsm to mux
   logic                                cpu_rd_idle;
   logic                                issue_en;
   logic                                clear;
   logic                                finish;
   logic                                issue_last;
   logic                                resp_last;
   logic [$clog2(`HAWK_PAGE_LINES)-1:0] issue_idx;
   mem_resp_t                           eng_resp;     // page lines only
   cpu_req_t                            fwd_req;      // rebased, stall applied

   hawk_cpu_stall u_cpu_stall (
      .clk_i, .arst_n_i, .uart_boot_en_i,
      .busy_i      (busy),
      .cpu_req_i,
      .fwd_req_o   (fwd_req),
      .cpu_stall_o
   );

   hawk_mem_mux u_mem_mux (
      .clk_i, .arst_n_i,
      .eng_own_i     (eng_own),
      .fwd_req_i     (fwd_req),
      .issue_en_i    (issue_en),
      .issue_idx_i   (issue_idx),
      .cmd_page_i, .mem_resp_i, .mem_req_o, .cpu_resp_o,
      .eng_resp_o    (eng_resp),
      .cpu_rd_idle_o (cpu_rd_idle)
   );

   hawk_ctrl_fsm u_ctrl_fsm (
      .clk_i, .arst_n_i, .cmd_start_i, .hawk_inactive_i,
      .cpu_rd_idle_i (cpu_rd_idle),
      .issue_last_i  (issue_last),
      .resp_last_i   (resp_last),
      .busy_o        (busy),
      .eng_own_o     (eng_own),
      .issue_en_o    (issue_en),
      .clear_o       (clear),
      .finish_o      (finish),
      .cmd_done_o
   );

   hawk_line_counter u_line_counter (
      .clk_i, .arst_n_i,
      .clear_i      (clear),
      .issue_en_i   (issue_en),
      .resp_valid_i (eng_resp.valid),  // counts page lines back
      .issue_idx_o  (issue_idx),
      .issue_last_o (issue_last),
      .resp_last_o  (resp_last)
   );

   hawk_zero_detect u_zero_detect (
      .clk_i, .arst_n_i,
      .clear_i  (clear),
      .line_i   (eng_resp),
      .finish_i (finish),
      .result_o
   );

endmodule

// File: verification/hawk_core_chk.sv
////////////////////
// hawk core checker
// port protocol assertions, bound to the top level
////////////////////
`timescale 1ns/1ps

module hawk_core_chk
   import hawk_mem_pkg::*;
(
   input logic      clk_i,
   input logic      arst_n_i,
   input logic      cmd_done_o,
   input cpu_resp_t cpu_resp_o,
   input mem_resp_t mem_resp_i,
   input mem_req_t  mem_req_o
);

   // done is a single cycle pulse
   done_pulse_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      cmd_done_o |=> !cmd_done_o)
      else $error("cmd_done_o high for two cycles in a row");

   // cpu only ever sees data the mc returned
   resp_route_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      cpu_resp_o.valid |-> mem_resp_i.valid)
      else $error("cpu_resp_o valid without a memory response");

   req_known_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !$isunknown(mem_req_o.valid))
      else $error("mem_req_o valid unknown after reset");

endmodule

bind hawk_core hawk_core_chk hawk_core_chk_inst (.*);

// File: verification/tb_hawk_core.sv
////////////////////
// hawk core testbench
// random cpu traffic, page compression, stall and inactive runs
// checked against an in-order memory model and reference arrays
////////////////////
`timescale 1ns/1ps
`include "hawk_defines.svh"

module tb_hawk_core
   import hawk_mem_pkg::*, hawk_comp_pkg::*;
();

   localparam int          N_RAND      = 48;            // idle cpu accesses
   localparam int          N_PAGES     = 12;
   localparam int          N_STALL     = 4;             // pages with a parked request
   localparam int          N_INACT     = 10;
   localparam int          NUM_OPS     = N_RAND + N_PAGES + 2 * N_STALL + N_INACT + 3;
   localparam logic [31:0] CPU_REGION  = 32'h0001_0000; // rebased cpu lines
   localparam logic [31:0] PAGE_REGION = 32'h0020_0000; // pages kept apart from cpu lines

   logic                    clk_i;
   logic                    arst_n_i;
   logic                    uart_boot_en_i;
   logic                    hawk_inactive_i;
   cpu_req_t                cpu_req_i;
   logic                    cmd_start_i;
   logic [`HAWK_ADDR_W-1:0] cmd_page_i;
   mem_resp_t               mem_resp_i = '0;
   logic                    cpu_stall_o;
   cpu_resp_t               cpu_resp_o;
   mem_req_t                mem_req_o;
   logic                    cmd_done_o;
   comp_result_t            result_o;

   logic [`HAWK_LINE_W-1:0] mem_model [logic [31:0]];  // contents behind the mc port
   logic [`HAWK_LINE_W-1:0] ref_mem [logic [31:0]];    // rebased cpu view
   mem_req_t                exp_req_q[$];
   int                      exp_req_done_q[$];         // done pulses owed first
   cpu_resp_t               exp_rsp_q[$];
   comp_result_t            exp_res_q[$];
   logic [`HAWK_LINE_W-1:0] rsp_data_q[$];             // reads in flight
   int                      rsp_due_q[$];
   int                      cyc      = 0;
   int                      last_due = 0;
   int                      done_cnt = 0;

   hawk_core hawk_core_inst (.*);

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   initial begin
      repeat (NUM_OPS * 60) @(posedge clk_i);
      fail_run("watchdog expired before the test sequence finished");
   end

   ////////////////////
   // reporting and compares
   ////////////////////
   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
      if (got !== exp) fail_run($sformatf("ERROR mem_req_o got %h exp %h", got, exp));
   endtask

   task automatic check_cpu_resp(input cpu_resp_t got, input cpu_resp_t exp);
      if (got !== exp) fail_run($sformatf("ERROR cpu_resp_o got %h exp %h", got, exp));
   endtask

   task automatic check_result(input comp_result_t got, input comp_result_t exp);
      if (got !== exp) fail_run($sformatf("ERROR result_o got %h exp %h", got, exp));
   endtask

   // fill for unwritten lines built from every address bit
   function automatic logic [`HAWK_LINE_W-1:0] fill_line(input logic [31:0] a);
      return {a ^ 32'h5a5a_0f0f, ~a, {a[15:0], a[31:16]}, a + 32'h1234_5678};
   endfunction

   ////////////////////
   // memory model and monitors
   ////////////////////
   always @(posedge clk_i) begin
      int                      lat;
      int                      due;
      logic [`HAWK_LINE_W-1:0] rd;
      cyc = cyc + 1;
      if (arst_n_i && cmd_done_o) begin
         if (exp_res_q.size() == 0) fail_run("cmd_done_o with no page operation started");
         check_result(result_o, exp_res_q.pop_front());
         done_cnt <= done_cnt + 1;
      end
      if (arst_n_i && mem_req_o.valid) begin
         if (exp_req_q.size() == 0) fail_run("memory request with none expected");
         check_mem_req(mem_req_o, exp_req_q.pop_front());
         if (done_cnt < exp_req_done_q.pop_front())
            fail_run("parked cpu request reached memory before cmd_done_o");
         if (mem_req_o.we) begin
            mem_model[mem_req_o.addr] = mem_req_o.wdata;
         end else begin
            rd  = mem_model.exists(mem_req_o.addr) ? mem_model[mem_req_o.addr]
                                                   : fill_line(mem_req_o.addr);
            lat = int'($urandom_range(4, 1));
            due = cyc + lat - 1;                  // driven now means next cycle
            if (due <= last_due) due = last_due + 1;  // in order and one per cycle
            last_due = due;
            rsp_data_q.push_back(rd);
            rsp_due_q.push_back(due);
         end
      end
      if (rsp_due_q.size() != 0 && rsp_due_q[0] == cyc) begin
         mem_resp_i <= {1'b1, rsp_data_q.pop_front()};
         void'(rsp_due_q.pop_front());
      end else begin
         mem_resp_i <= '0;
      end
      if (arst_n_i && cpu_resp_o.valid) begin
         if (exp_rsp_q.size() == 0) fail_run("cpu read data with no cpu read outstanding");
         check_cpu_resp(cpu_resp_o, exp_rsp_q.pop_front());
      end
   end

   ////////////////////
   // stimulus
   ////////////////////
   // one random cpu access driven right after a rising edge
   task automatic random_cpu_op(input int need_done);
      logic                    we;
      logic [31:0]             rb;
      logic [`HAWK_LINE_W-1:0] wd;
      mem_req_t                er;
      cpu_resp_t               rr;
      we = 1'($urandom_range(1, 0));
      rb = CPU_REGION + 32'($urandom_range(31, 0)) * 32'(`HAWK_LINE_BYTES);
      wd = we ? {$urandom, $urandom, $urandom, $urandom} : '0;
      er = '{valid: 1'b1, we: we, addr: rb, wdata: wd};   // mc sees the rebased address
      exp_req_q.push_back(er);
      exp_req_done_q.push_back(need_done);
      if (we) begin
         ref_mem[rb] = wd;
      end else begin
         rr.valid = 1'b1;
         rr.rdata = ref_mem.exists(rb) ? ref_mem[rb] : fill_line(rb);
         exp_rsp_q.push_back(rr);
      end
      cpu_req_i <= '{valid: 1'b1, we: we,
                     addr: uart_boot_en_i ? rb : rb + `HAWK_DRAM_BASE, wdata: wd};
   endtask

   task automatic cpu_step();
      @(posedge clk_i);
      while (cpu_stall_o) @(posedge clk_i);     // cpu holds off while parked
      random_cpu_op(0);
      @(posedge clk_i);
      cpu_req_i.valid <= 1'b0;
   endtask

   task automatic wait_done(input int target);
      int n;
      n = 0;
      while (done_cnt < target) begin
         if (n == 100) fail_run("no cmd_done_o within 100 cycles of the start pulse");
         @(posedge clk_i);
         n++;
      end
   endtask

   // fill a page, start it, optionally park a cpu request mid operation
   task automatic run_page(input int idx, input bit with_cpu);
      comp_result_t er;
      mem_req_t     lr;
      hawk_line_u   ln;
      logic [31:0]  pg;
      int           nz;
      int           tgt;
      pg = PAGE_REGION + 32'(idx) * 32'(`HAWK_PAGE_LINES * `HAWK_LINE_BYTES);
      nz = 0;
      er = '0;
      for (int l = 0; l < `HAWK_PAGE_LINES; l++) begin
         for (int c = 0; c < `HAWK_CHUNKS; c++) begin
            ln.chunk[c] = ($urandom_range(1, 0) != 0) ? $urandom : 32'h0;  // half zero
            if (ln.chunk[c] != '0) nz++;
         end
         er.zero_vec[l] = (ln.flat == '0);
         mem_model[pg + 32'(l) * 32'(`HAWK_LINE_BYTES)] = ln.flat;
         ref_mem[pg + 32'(l) * 32'(`HAWK_LINE_BYTES)]   = ln.flat;
      end
      er.size   = `HAWK_SIZE_W'(nz * `HAWK_CHUNK_BYTES);
      er.incomp = (nz * `HAWK_CHUNK_BYTES > `HAWK_COMP_THRESH);
      tgt = done_cnt + 1;
      @(posedge clk_i);
      cmd_page_i  <= pg;
      cmd_start_i <= 1'b1;
      if (!hawk_inactive_i) begin
         for (int l = 0; l < `HAWK_PAGE_LINES; l++) begin
            lr = '{valid: 1'b1, we: 1'b0,
                   addr: pg + 32'(l) * 32'(`HAWK_LINE_BYTES), wdata: '0};
            exp_req_q.push_back(lr);
            exp_req_done_q.push_back(0);
         end
         exp_res_q.push_back(er);
      end
      @(posedge clk_i);
      cmd_start_i <= 1'b0;
      if (with_cpu) begin
         repeat ($urandom_range(4, 0)) @(posedge clk_i);  // well inside the op
         random_cpu_op(tgt);
         @(posedge clk_i);
         cpu_req_i.valid <= 1'b0;
         @(posedge clk_i);
         if (!cpu_stall_o) fail_run("cpu_stall_o stayed low for a request during a page op");
      end
      if (hawk_inactive_i) begin
         repeat (60) @(posedge clk_i);
         if (done_cnt != tgt - 1) fail_run("cmd_done_o pulsed while the engine was inactive");
      end else begin
         wait_done(tgt);
      end
   endtask

   initial begin
      int n;
      void'($urandom(32'hf8a1));
      arst_n_i        = 1'b0;
      uart_boot_en_i  = 1'b0;
      hawk_inactive_i = 1'b0;
      cmd_start_i     = 1'b0;
      cmd_page_i      = '0;
      cpu_req_i       = '0;
      repeat (10) @(posedge clk_i);
      arst_n_i <= 1'b1;
      @(posedge clk_i);
      if (cpu_stall_o || cmd_done_o || mem_req_o.valid || cpu_resp_o.valid)
         fail_run("outputs not at their reset values");
      check_result(result_o, '0);

      for (int i = 0; i < N_RAND; i++) begin
         if (i == N_RAND / 2) uart_boot_en_i <= 1'b1;   // second half in boot mode
         cpu_step();
      end
      @(posedge clk_i);
      uart_boot_en_i <= 1'b0;

      for (int p = 0; p < N_PAGES; p++) begin
         cpu_step();                                     // may leave a read to drain
         run_page(p, 1'b0);
      end
      for (int s = 0; s < N_STALL; s++) begin
         cpu_step();
         run_page(N_PAGES + s, 1'b1);
      end

      @(posedge clk_i);
      hawk_inactive_i <= 1'b1;
      run_page(N_PAGES + N_STALL, 1'b0);
      for (int i = 0; i < N_INACT; i++) cpu_step();
      @(posedge clk_i);
      hawk_inactive_i <= 1'b0;

      n = 0;
      while ((exp_req_q.size() != 0 || exp_rsp_q.size() != 0) && n < 50) begin
         @(posedge clk_i);
         n++;
      end
      if (exp_req_q.size() != 0 || exp_rsp_q.size() != 0 || exp_res_q.size() != 0) begin
         fail_run("expected memory or cpu traffic never arrived");
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

// File: list.f
+incdir+design
design/hawk_mem_pkg.sv
design/hawk_comp_pkg.sv
design/hawk_ctrl_fsm.sv
design/hawk_line_counter.sv
design/hawk_zero_detect.sv
design/hawk_cpu_stall.sv
design/hawk_mem_mux.sv
design/hawk_core.sv
verification/hawk_core_chk.sv
verification/tb_hawk_core.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the hawk_core testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module tb_hawk_core -o tb_hawk_core &&
   ./obj_dir/tb_hawk_core | tee /dev/stderr | grep -q "Result: PASSED" &&
   echo "simulation passed" ||
   { echo "simulation failed"; exit 1; }
